//--- bam_avmm_bridge.f
bam_avmm_pkg.sv
bam_cmd_fetch.sv
bam_avmm_issue.sv
bam_cpl_buffer.sv
bam_avmm_top.sv
tb_bam_avmm.sv

//--- bam_avmm_issue.sv
`timescale 1ns/1ps

module bam_avmm_issue import bam_avmm_pkg::*; (
  input  logic              clk,
  input  logic              srst_reg,
  input  issue_req_t        issue_i,
  output logic              avm_write_o,
  output logic              avm_read_o,
  output logic [ADDR_W-1:0] avm_address_o,
  output logic [DATA_W-1:0] avm_writedata_o,
  output logic [BE_W-1:0]   avm_byteenable_o,
  output logic [BCNT_W-1:0] avm_burstcount_o,
  output rd_issue_t         rd_issue_o
);

  logic              wr_q;
  logic              rd_q;
  logic              blocked_q;
  logic              out_of_range;
  logic [ADDR_W-1:0] addr_q;
  logic [BCNT_W-1:0] bcnt_q;
  logic [DATA_W-1:0] wdata_q;
  logic [BE_W-1:0]   be_q;

  // any address bit above the window is an illegal target
  assign out_of_range = |issue_i.cmd.address[ADDR_W-1:WINDOW_BITS];

  // --------------------
  // strobe stage
  // --------------------
  always_ff @(posedge clk) begin
    if (srst_reg) begin
      wr_q      <= 1'b0;
      rd_q      <= 1'b0;
      blocked_q <= 1'b0;
    end else begin
      wr_q      <= issue_i.wr_beat;
      rd_q      <= issue_i.rd_strobe;
      blocked_q <= out_of_range;
    end
  end

  // --------------------
  // payload stage
  // --------------------
  always_ff @(posedge clk) begin
    addr_q  <= {issue_i.cmd.address[ADDR_W-1:WORD_LSB], {WORD_LSB{1'b0}}};
    bcnt_q  <= issue_i.cmd.burstcount;
    wdata_q <= issue_i.beat.data;
    // reads carry their enables in the command, writes per beat
    be_q    <= issue_i.rd_strobe ? issue_i.cmd.byteenable : issue_i.beat.byteenable;
  end

  assign avm_write_o      = wr_q & ~blocked_q;
  assign avm_read_o       = rd_q & ~blocked_q;
  assign avm_address_o    = addr_q;
  assign avm_burstcount_o = bcnt_q;
  assign avm_writedata_o  = blocked_q ? '0 : wdata_q;
  assign avm_byteenable_o = blocked_q ? '0 : be_q;

  // buffer still needs blocked reads to produce poison entries
  assign rd_issue_o.rd_strobe  = rd_q;
  assign rd_issue_o.blocked    = blocked_q;
  assign rd_issue_o.burstcount = bcnt_q;

endmodule

//--- bam_avmm_pkg.sv
package bam_avmm_pkg;

  // --------------------
  // data path widths
  // --------------------
  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 64;
  localparam int BE_W     = DATA_W / 8;
  localparam int WORD_LSB = 3;

  // burst and window limits
  localparam int BCNT_W      = 4;
  localparam int MAX_BURST   = 8;
  localparam int WINDOW_BITS = 12;

  // completion buffer sizing
  localparam int CPL_DEPTH = 32;
  localparam int CPL_AW    = 5;
  localparam int CREDIT_W  = 6;

  // fill word returned for reads outside the window
  localparam logic [DATA_W-1:0] POISON_DATA = {2{32'hDEAD0ADD}};

  // --------------------
  // types
  // --------------------
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_POP,
    FETCH_WR,
    FETCH_RD
  } fetch_state_e;

  // command FIFO entry, byteenable only applies to reads
  typedef struct packed {
    logic              is_write;
    logic [ADDR_W-1:0] address;
    logic [BE_W-1:0]   byteenable;
    logic [BCNT_W-1:0] burstcount;
  } bam_cmd_t;

  typedef struct packed {
    logic [BE_W-1:0]   byteenable;
    logic [DATA_W-1:0] data;
  } wr_beat_t;

  typedef struct packed {
    logic     wr_beat;
    logic     rd_strobe;
    wr_beat_t beat;
    bam_cmd_t cmd;
  } issue_req_t;

  typedef struct packed {
    logic              rd_strobe;
    logic              blocked;
    logic [BCNT_W-1:0] burstcount;
  } rd_issue_t;

  typedef struct packed {
    logic              err;
    logic [DATA_W-1:0] data;
  } cpl_entry_t;

endpackage

//--- bam_avmm_stimulus.txt
# record: name W|R addr(hex) burstcount be(hex) err_flag hold_consumer sync
# entry lines: write -> be(hex) data(hex) repeat, read -> err data(hex) repeat
wr_burst W 00000100 4 00 0 0 1
ff 1111111111111111 1
ff 2222222222222222 1
ff 3333333333333333 1
ff 4444444444444444 1
rd_burst R 00000104 4 ff 0 0 1
0 1111111111111111 1
0 2222222222222222 1
0 3333333333333333 1
0 4444444444444444 1
be_write W 00000200 1 00 0 0 1
0f 1122334455667788 1
be_read R 00000200 1 ff 0 0 1
0 C0DE004055667788 1
blk_write W 00001100 2 00 0 0 1
ff aaaaaaaaaaaaaaaa 2
alias_read R 00000100 1 ff 0 0 1
0 1111111111111111 1
blk_read R 00002008 3 ff 0 0 1
1 DEAD0ADDDEAD0ADD 3
err_read R 00000300 2 ff 1 0 1
1 C0DE0060F00D0060 1
1 C0DE0061F00D0061 1
cr_fill W 00000400 8 00 0 0 1
ff 0123456789abcdef 8
cr_rd0 R 00000400 8 ff 0 1 0
0 0123456789abcdef 8
cr_rd1 R 00000400 8 ff 0 1 0
0 0123456789abcdef 8
cr_rd2 R 00000400 8 ff 0 1 0
0 0123456789abcdef 8
cr_rd3 R 00000400 8 ff 0 1 0
0 0123456789abcdef 8
cr_rd4 R 00000400 8 ff 0 1 1
0 0123456789abcdef 8

//--- bam_avmm_top.sv
`timescale 1ns/1ps

module bam_avmm_top import bam_avmm_pkg::*; (
  input  logic              clk,
  input  logic              srst_reg,
  // command and data FIFOs
  input  logic              cmd_fifo_empty_i,
  input  bam_cmd_t          cmd_fifo_rdata_i,
  output logic              cmd_fifo_rreq_o,
  input  wr_beat_t          data_fifo_rdata_i,
  output logic              data_fifo_rreq_o,
  // Avalon-MM master
  output logic              avm_write_o,
  output logic              avm_read_o,
  output logic [ADDR_W-1:0] avm_address_o,
  output logic [DATA_W-1:0] avm_writedata_o,
  output logic [BE_W-1:0]   avm_byteenable_o,
  output logic [BCNT_W-1:0] avm_burstcount_o,
  input  logic              avm_waitrequest_i,
  input  logic [DATA_W-1:0] avm_readdata_i,
  input  logic              avm_readdatavalid_i,
  input  logic [1:0]        avm_response_i,
  // completion consumer
  input  logic              cpl_rdreq_i,
  output logic              cpl_valid_o,
  output cpl_entry_t        cpl_rdata_o
);

  issue_req_t issue_req;
  rd_issue_t  rd_issue;
  logic       credit_ok;

  bam_cmd_fetch u_fetch (
    .clk               (clk),
    .srst_reg          (srst_reg),
    .cmd_fifo_empty_i  (cmd_fifo_empty_i),
    .cmd_fifo_rdata_i  (cmd_fifo_rdata_i),
    .data_fifo_rdata_i (data_fifo_rdata_i),
    .avm_waitrequest_i (avm_waitrequest_i),
    .credit_ok_i       (credit_ok),
    .cmd_fifo_rreq_o   (cmd_fifo_rreq_o),
    .data_fifo_rreq_o  (data_fifo_rreq_o),
    .issue_o           (issue_req)
  );

  bam_avmm_issue u_issue (
    .clk              (clk),
    .srst_reg         (srst_reg),
    .issue_i          (issue_req),
    .avm_write_o      (avm_write_o),
    .avm_read_o       (avm_read_o),
    .avm_address_o    (avm_address_o),
    .avm_writedata_o  (avm_writedata_o),
    .avm_byteenable_o (avm_byteenable_o),
    .avm_burstcount_o (avm_burstcount_o),
    .rd_issue_o       (rd_issue)
  );

  bam_cpl_buffer u_cpl (
    .clk                 (clk),
    .srst_reg            (srst_reg),
    .rd_issue_i          (rd_issue),
    .avm_readdata_i      (avm_readdata_i),
    .avm_readdatavalid_i (avm_readdatavalid_i),
    .avm_response_i      (avm_response_i),
    .cpl_rdreq_i         (cpl_rdreq_i),
    .cpl_valid_o         (cpl_valid_o),
    .cpl_rdata_o         (cpl_rdata_o),
    .credit_ok_o         (credit_ok)
  );

endmodule

//--- bam_cmd_fetch.sv
`timescale 1ns/1ps

module bam_cmd_fetch import bam_avmm_pkg::*; (
  input  logic       clk,
  input  logic       srst_reg,
  input  logic       cmd_fifo_empty_i,
  input  bam_cmd_t   cmd_fifo_rdata_i,
  input  wr_beat_t   data_fifo_rdata_i,
  input  logic       avm_waitrequest_i,
  input  logic       credit_ok_i,
  output logic       cmd_fifo_rreq_o,
  output logic       data_fifo_rreq_o,
  output issue_req_t issue_o
);

  fetch_state_e      state_q;
  fetch_state_e      state_d;
  logic              cmd_avail_reg;
  logic              wait_req_reg;
  logic              credit_ok_reg;
  logic              idle_settled;
  logic [BCNT_W-1:0] beat_cnt;
  bam_cmd_t          cmd_reg;

  // --------------------
  // input sampling
  // --------------------
  always_ff @(posedge clk) begin
    if (srst_reg) begin
      cmd_avail_reg <= 1'b0;
      wait_req_reg  <= 1'b1;
      credit_ok_reg <= 1'b0;
      idle_settled  <= 1'b0;
    end else begin
      cmd_avail_reg <= ~cmd_fifo_empty_i;
      wait_req_reg  <= avm_waitrequest_i;
      credit_ok_reg <= credit_ok_i;
      // first idle cycle after a command sees stale fifo and credit levels
      idle_settled  <= (state_q == FETCH_IDLE);
    end
  end

  // --------------------
  // command FSM
  // --------------------
  always_ff @(posedge clk) begin
    if (srst_reg) begin
      state_q <= FETCH_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH_IDLE: begin
        if (idle_settled && cmd_avail_reg && !wait_req_reg && credit_ok_reg) begin
          state_d = FETCH_POP;
        end
      end
      // direction comes straight from the fifo head
      FETCH_POP: begin
        state_d = cmd_fifo_rdata_i.is_write ? FETCH_WR : FETCH_RD;
      end
      FETCH_WR: begin
        if (beat_cnt == BCNT_W'(1)) begin
          state_d = FETCH_IDLE;
        end
      end
      FETCH_RD: begin
        state_d = FETCH_IDLE;
      end
      default: begin
        state_d = FETCH_IDLE;
      end
    endcase
  end

  // remaining write beats of the current burst
  always_ff @(posedge clk) begin
    if (srst_reg) begin
      beat_cnt <= '0;
    end else if (state_q == FETCH_POP) begin
      beat_cnt <= cmd_fifo_rdata_i.burstcount;
    end else if (state_q == FETCH_WR) begin
      beat_cnt <= beat_cnt - BCNT_W'(1);
    end
  end

  // held for the whole command
  always_ff @(posedge clk) begin
    if (state_q == FETCH_POP) begin
      cmd_reg <= cmd_fifo_rdata_i;
    end
  end

  assign cmd_fifo_rreq_o  = (state_q == FETCH_POP);
  assign data_fifo_rreq_o = (state_q == FETCH_WR);

  assign issue_o.wr_beat   = (state_q == FETCH_WR);
  assign issue_o.rd_strobe = (state_q == FETCH_RD);
  assign issue_o.beat      = data_fifo_rdata_i;
  assign issue_o.cmd       = cmd_reg;

endmodule

//--- bam_cpl_buffer.sv
`timescale 1ns/1ps

module bam_cpl_buffer import bam_avmm_pkg::*; (
  input  logic              clk,
  input  logic              srst_reg,
  input  rd_issue_t         rd_issue_i,
  input  logic [DATA_W-1:0] avm_readdata_i,
  input  logic              avm_readdatavalid_i,
  input  logic [1:0]        avm_response_i,
  input  logic              cpl_rdreq_i,
  output logic              cpl_valid_o,
  output cpl_entry_t        cpl_rdata_o,
  output logic              credit_ok_o
);

  logic                beat_valid_q;
  cpl_entry_t          beat_q;
  logic [CREDIT_W-1:0] poison_cnt;
  logic [CREDIT_W-1:0] poison_add;
  logic                poison_wr;
  logic                wr_en;
  cpl_entry_t          wr_entry;
  logic [CPL_AW-1:0]   wr_ptr;
  logic [CPL_AW-1:0]   rd_ptr;
  logic [CREDIT_W-1:0] outstanding;
  logic [CREDIT_W-1:0] out_add;
  logic [CREDIT_W:0]   credit_need;
  cpl_entry_t          cpl_mem [CPL_DEPTH];

  // --------------------
  // read beat capture
  // --------------------
  always_ff @(posedge clk) begin
    if (srst_reg) begin
      beat_valid_q <= 1'b0;
    end else begin
      beat_valid_q <= avm_readdatavalid_i;
    end
  end

  always_ff @(posedge clk) begin
    beat_q.data <= avm_readdata_i;
    beat_q.err  <= |avm_response_i;
  end

  // --------------------
  // poison fill
  // --------------------
  assign poison_add = (rd_issue_i.rd_strobe && rd_issue_i.blocked) ?
                      CREDIT_W'(rd_issue_i.burstcount) : '0;

  // slave beats have priority, poison takes the gaps
  assign poison_wr = !beat_valid_q && (poison_cnt != '0);

  always_ff @(posedge clk) begin
    if (srst_reg) begin
      poison_cnt <= '0;
    end else begin
      poison_cnt <= poison_cnt + poison_add - CREDIT_W'(poison_wr);
    end
  end

  always_comb begin
    if (beat_valid_q) begin
      wr_entry = beat_q;
    end else begin
      wr_entry.err  = 1'b1;
      wr_entry.data = POISON_DATA;
    end
  end

  assign wr_en       = beat_valid_q | poison_wr;
  assign cpl_valid_o = wr_en;

  // --------------------
  // completion RAM
  // --------------------
  always_ff @(posedge clk) begin
    if (wr_en) begin
      cpl_mem[wr_ptr] <= wr_entry;
    end
  end

  always_ff @(posedge clk) begin
    if (srst_reg) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + CPL_AW'(1);
      end
      if (cpl_rdreq_i) begin
        rd_ptr <= rd_ptr + CPL_AW'(1);
      end
    end
  end

  // head entry is shown ahead of the read request
  assign cpl_rdata_o = cpl_mem[rd_ptr];

  // --------------------
  // credit monitor
  // --------------------
  assign out_add = rd_issue_i.rd_strobe ? CREDIT_W'(rd_issue_i.burstcount) : '0;

  always_ff @(posedge clk) begin
    if (srst_reg) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + out_add - CREDIT_W'(cpl_rdreq_i);
    end
  end

  // count a read in its strobe cycle, so the fetch side sees it in time
  assign credit_need = {1'b0, outstanding} + {1'b0, out_add} + (CREDIT_W + 1)'(MAX_BURST);
  assign credit_ok_o = (credit_need <= (CREDIT_W + 1)'(CPL_DEPTH));

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f bam_avmm_bridge.f --top-module tb_bam_avmm \
  -o tb_bam_avmm_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_bam_avmm_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

if ! grep -q "PASS: all tests" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi

exit 0

//--- tb_bam_avmm.sv
`timescale 1ns/1ps

module tb_bam_avmm import bam_avmm_pkg::*; ();

  logic              clk = 1'b0;
  logic              srst_reg = 1'b1;
  logic              cmd_fifo_empty_i = 1'b1;
  bam_cmd_t          cmd_fifo_rdata_i = '0;
  logic              cmd_fifo_rreq_o;
  wr_beat_t          data_fifo_rdata_i = '0;
  logic              data_fifo_rreq_o;
  logic              avm_write_o;
  logic              avm_read_o;
  logic [ADDR_W-1:0] avm_address_o;
  logic [DATA_W-1:0] avm_writedata_o;
  logic [BE_W-1:0]   avm_byteenable_o;
  logic [BCNT_W-1:0] avm_burstcount_o;
  logic              avm_waitrequest_i = 1'b0;
  logic [DATA_W-1:0] avm_readdata_i = '0;
  logic              avm_readdatavalid_i = 1'b0;
  logic [1:0]        avm_response_i = 2'b00;
  logic              cpl_rdreq_i = 1'b0;
  logic              cpl_valid_o;
  cpl_entry_t        cpl_rdata_o;

  // stimulus records, entries hold write beats or expected completions
  logic [127:0] rec_name [64];
  logic         rec_wr [64];
  logic [31:0]  rec_addr [64];
  int           rec_bcnt [64];
  logic [7:0]   rec_be [64];
  int           rec_flag [64];
  int           rec_hold [64];
  int           rec_sync [64];
  int           rec_first [64];
  logic [7:0]   ent_a [512];
  logic [63:0]  ent_d [512];
  int           n_rec = 0;
  int           n_ent = 0;
  bit           loaded = 1'b0;

  bam_cmd_t     cmd_q [$];
  wr_beat_t     data_q [$];
  cpl_entry_t   exp_q [$];
  int           exp_idx [$];

  logic [63:0]  mem [512];
  bit           err_word [512];
  int           job_word [$];
  int           job_cnt [$];
  bit           job_err [$];
  int           wr_idx = 0;
  int           rd_word = 0;
  int           rd_left = 0;
  int           rd_delay = 0;
  bit           rd_err = 1'b0;
  bit           cmd_popped = 1'b0;

  int           wr_count = 0;
  int           rd_count = 0;
  int           iss = 0;
  int           pop = 0;
  int           base_iss = 0;
  int           base_pop = 0;
  int           avail = 0;
  bit           hold_cons = 1'b0;
  int           errors = 0;
  int           checks = 0;

  bam_avmm_top UUT (.*);

  always #10 clk = ~clk;

  task automatic check(input logic [127:0] name, input logic [71:0] exp_v,
                       input logic [71:0] act_v);
    checks++;
    if (exp_v !== act_v) begin
      errors++;
      $display("FAIL %0s expected %h actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0 || cmd_q.size() != 0 || data_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (8) @(posedge clk);
  endtask

  // --------------------
  // FIFO drivers
  // --------------------
  always @(posedge clk) begin
    if (cmd_fifo_rreq_o) begin
      if (cmd_q.size() == 0) begin
        errors++;
        $display("ERROR: DUT popped the command FIFO while it was empty");
      end else begin
        cmd_q.delete(0);
      end
    end
    if (data_fifo_rreq_o) begin
      if (data_q.size() == 0) begin
        errors++;
        $display("ERROR: DUT popped the data FIFO while it was empty");
      end else begin
        data_q.delete(0);
      end
    end
    cmd_fifo_empty_i <= (cmd_q.size() == 0);
    if (cmd_q.size() != 0) begin
      cmd_fifo_rdata_i <= cmd_q[0];
    end
    if (data_q.size() != 0) begin
      data_fifo_rdata_i <= data_q[0];
    end
  end

  // --------------------
  // slave memory model
  // --------------------
  always @(posedge clk) begin
    logic [8:0] w;
    avm_readdatavalid_i <= 1'b0;
    if (avm_write_o) begin
      w = avm_address_o[11:3] + 9'(wr_idx);
      for (int b = 0; b < BE_W; b++) begin
        if (avm_byteenable_o[b]) begin
          mem[w][8*b +: 8] = avm_writedata_o[8*b +: 8];
        end
      end
      wr_count <= wr_count + 1;
      wr_idx = (wr_idx + 1 == int'(avm_burstcount_o)) ? 0 : wr_idx + 1;
    end
    if (avm_read_o) begin
      job_word.push_back(int'(avm_address_o[11:3]));
      job_cnt.push_back(int'(avm_burstcount_o));
      job_err.push_back(err_word[avm_address_o[11:3]]);
      rd_count <= rd_count + 1;
      iss <= iss + int'(avm_burstcount_o);
    end
    if (rd_left == 0 && job_word.size() != 0) begin
      rd_word  = job_word.pop_front();
      rd_left  = job_cnt.pop_front();
      rd_err   = job_err.pop_front();
      rd_delay = int'($urandom_range(6, 1));
    end else if (rd_left != 0) begin
      if (rd_delay > 1) begin
        rd_delay--;
      end else begin
        avm_readdatavalid_i <= 1'b1;
        avm_readdata_i      <= mem[9'(rd_word)];
        avm_response_i      <= rd_err ? 2'b10 : 2'b00;
        rd_word++;
        rd_left--;
      end
    end
    // a popped command puts its first strobe out two cycles later
    cmd_popped <= cmd_fifo_rreq_o;
    // idle waitrequest only between transfers
    avm_waitrequest_i <= (wr_idx == 0) && !avm_write_o && !data_fifo_rreq_o &&
                         !cmd_fifo_rreq_o && !cmd_popped &&
                         ($urandom_range(3, 0) == 0);
  end

  // --------------------
  // completion consumer and credit monitor
  // --------------------
  always @(posedge clk) begin
    if (cpl_rdreq_i) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR: completion popped with no entry expected");
      end else begin
        check(rec_name[exp_idx[0]], {7'd0, exp_q[0]}, {7'd0, cpl_rdata_o});
        exp_q.delete(0);
        exp_idx.delete(0);
      end
      pop <= pop + 1;
    end
    if (cpl_valid_o) begin
      avail++;
    end
    if (!hold_cons && avail > 0) begin
      cpl_rdreq_i <= 1'b1;
      avail--;
    end else begin
      cpl_rdreq_i <= 1'b0;
    end
    if ((iss - base_iss) - (pop - base_pop) > CPL_DEPTH) begin
      errors++;
      $display("ERROR: read beats in flight exceed the completion buffer depth");
    end
  end

  // --------------------
  // main sequence
  // --------------------
  initial begin
    int           fd;
    int           rc;
    int           need;
    int           rep;
    int           exp_wr;
    int           exp_rd;
    bit           blocked;
    string        line;
    logic [127:0] nm;
    logic [7:0]   kind;
    logic [31:0]  addr;
    logic [7:0]   a;
    logic [63:0]  d;
    bam_cmd_t     cmd;
    wr_beat_t     wb;
    cpl_entry_t   ce;

    need   = 0;
    exp_wr = 0;
    exp_rd = 0;
    rc = $urandom(32'h400a);
    for (int i = 0; i < 512; i++) begin
      mem[i]      = {16'hC0DE, 16'(i), 16'hF00D, 16'(i)};
      err_word[i] = 1'b0;
    end

    fd = $fopen("bam_avmm_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("ERROR: could not open the stimulus file");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.getc(0) == "#") begin
          continue;
        end
        if (need > 0) begin
          rc = $sscanf(line, "%h %h %d", a, d, rep);
          for (int k = 0; k < rep; k++) begin
            ent_a[n_ent] = a;
            ent_d[n_ent] = d;
            n_ent++;
          end
          need -= rep;
        end else begin
          rc = $sscanf(line, "%s %s %h %d %h %d %d %d", nm, kind, addr,
                       rec_bcnt[n_rec], rec_be[n_rec], rec_flag[n_rec],
                       rec_hold[n_rec], rec_sync[n_rec]);
          rec_name[n_rec]  = nm;
          rec_wr[n_rec]    = (kind == "W");
          rec_addr[n_rec]  = addr;
          rec_first[n_rec] = n_ent;
          need = rec_bcnt[n_rec];
          n_rec++;
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;

    repeat (4) @(posedge clk);
    srst_reg <= 1'b0;
    repeat (4) @(posedge clk);

    for (int r = 0; r < n_rec; r++) begin
      @(negedge clk);
      blocked = |rec_addr[r][31:12];
      for (int k = rec_first[r]; k < rec_first[r] + rec_bcnt[r]; k++) begin
        if (rec_wr[r]) begin
          wb.byteenable = ent_a[k];
          wb.data       = ent_d[k];
          data_q.push_back(wb);
        end else begin
          ce.err  = ent_a[k][0];
          ce.data = ent_d[k];
          exp_q.push_back(ce);
          exp_idx.push_back(r);
        end
      end
      if (rec_flag[r] != 0) begin
        err_word[rec_addr[r][11:3]] = 1'b1;
      end
      cmd.is_write   = rec_wr[r];
      cmd.address    = rec_addr[r];
      cmd.byteenable = rec_be[r];
      cmd.burstcount = BCNT_W'(rec_bcnt[r]);
      cmd_q.push_back(cmd);
      if (!blocked) begin
        if (rec_wr[r]) begin
          exp_wr += rec_bcnt[r];
        end else begin
          exp_rd += 1;
        end
      end
      if (rec_hold[r] != 0) begin
        hold_cons = 1'b1;
      end
      if (rec_sync[r] != 0) begin
        if (hold_cons) begin
          // buffer must fill to its depth and stall the rest
          repeat (150) @(posedge clk);
          check(rec_name[r], 72'(CPL_DEPTH), 72'((iss - base_iss) - (pop - base_pop)));
          @(negedge clk);
          hold_cons = 1'b0;
        end
        wait_idle();
        check(rec_name[r], 72'(exp_wr), 72'(wr_count));
        check(rec_name[r], 72'(exp_rd), 72'(rd_count));
        base_iss = iss;
        base_pop = pop;
      end
    end

    $display("run done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog, scaled by the number of records
  initial begin
    wait (loaded);
    repeat (n_rec * 200 + 20) @(posedge clk);
    $display("ERROR: run timed out before all records completed");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
